// File: flist.f
logic/elevator_pkg.sv
logic/call_register.sv
logic/door_sequencer.sv
logic/car_controller.sv
logic/elevator_top.sv
verif/elevator_checker.sv
verif/elevator_tb.sv

// File: logic/call_register.sv
// call register: set and clear memory for cab, hall-up and hall-down calls
`timescale 1ns/1ps
`default_nettype none

module call_register (
	input  wire                      clk,
	input  wire                      reset,
	input  wire elevator_pkg::call_set_t buttons,
	input  wire elevator_pkg::call_set_t cancel,
	output elevator_pkg::call_set_t      pending
);
	import elevator_pkg::*;

	call_set_t next_pending;

	// cancel wins over a press on the same bit
	always_comb begin
		next_pending.cab       = (pending.cab | buttons.cab) & ~cancel.cab;
		next_pending.hall_up   = (pending.hall_up | buttons.hall_up) & ~cancel.hall_up;
		next_pending.hall_down = (pending.hall_down | buttons.hall_down) & ~cancel.hall_down;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pending <= '0;	// no calls after reset
		end else begin
			pending <= next_pending;
		end
	end

endmodule

`default_nettype wire

// File: logic/car_controller.sv
// car controller: position, direction, travel, stop decision and call cancellation
`timescale 1ns/1ps
`default_nettype none

module car_controller (
	input  wire                      clk,
	input  wire                      reset,
	input  wire elevator_pkg::call_set_t pending,
	input  wire                      door_done,
	output elevator_pkg::motor_cmd_t     engine,
	output elevator_pkg::floor_t         level_display,
	output logic                     door_request,
	output logic                     parked,
	output elevator_pkg::call_set_t      cancel
);
	import elevator_pkg::*;

	localparam step_count_t LAST_STEP = step_count_t'(HALF_FLOOR_STEPS - 1);

	car_state_t  state;
	step_count_t step;
	logic        dir_up;	// 1 up, 0 down
	logic        door_busy;	// door is out of idle at this stop

	floor_mask_t all_calls;
	floor_mask_t floor_bit;
	floor_t      next_floor;
	logic        calls_above;
	logic        calls_below;
	logic        ahead;
	logic        behind;
	logic        call_here;
	logic        stop_next;
	logic        more_next;

	// any call strictly past floor f in the given direction
	function automatic logic beyond(input floor_mask_t calls, input floor_t f, input logic up);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < FLOOR_COUNT; i++) begin
			if (calls[i] && (up ? (i > f) : (i < f)))
				hit = 1'b1;
		end
		return hit;
	endfunction

	// direction rule for a car arriving at floor f
	function automatic logic stop_at(input call_set_t calls, input floor_t f, input logic up);
		floor_mask_t any;
		logic        same_dir;
		logic        other_dir;
		any       = calls.cab | calls.hall_up | calls.hall_down;
		same_dir  = up ? calls.hall_up[f] : calls.hall_down[f];
		other_dir = up ? calls.hall_down[f] : calls.hall_up[f];
		return calls.cab[f] || same_dir || (other_dir && !beyond(any, f, up));
	endfunction

	assign all_calls   = pending.cab | pending.hall_up | pending.hall_down;
	assign floor_bit   = floor_mask_t'(1) << level_display;
	assign next_floor  = dir_up ? level_display + 1'b1 : level_display - 1'b1;
	assign calls_above = beyond(all_calls, level_display, 1'b1);
	assign calls_below = beyond(all_calls, level_display, 1'b0);
	assign ahead       = dir_up ? calls_above : calls_below;
	assign behind      = dir_up ? calls_below : calls_above;
	assign call_here   = |(all_calls & floor_bit);
	assign stop_next   = stop_at(pending, next_floor, dir_up);
	assign more_next   = beyond(all_calls, next_floor, dir_up);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state         <= CAR_PARKED;
			step          <= '0;
			dir_up        <= 1'b1;
			level_display <= '0;
			door_request  <= 1'b0;
			door_busy     <= 1'b0;
		end else begin
			door_request <= 1'b0;	// one-cycle pulse
			if (door_request)
				door_busy <= 1'b1;
			else if (door_done)
				door_busy <= 1'b0;

			case (state)
				CAR_PARKED: begin
					if (call_here) begin
						state <= CAR_ARRIVE;	// door cycle in place
					end else if (ahead) begin
						state <= CAR_TRAVEL;
					end else if (behind) begin
						dir_up <= !dir_up;
						state  <= CAR_TRAVEL;
					end
				end
				CAR_TRAVEL: begin
					if (step == LAST_STEP) begin
						step          <= '0;
						level_display <= next_floor;	// floor reached
						if (stop_next)
							state <= CAR_ARRIVE;
						else if (!more_next)
							state <= CAR_PARKED;
					end else begin
						step <= step + 1'b1;
					end
				end
				CAR_ARRIVE: begin
					door_request <= 1'b1;
					state        <= CAR_SERVE;
				end
				CAR_SERVE: begin
					if (door_done) begin
						if (ahead) begin
							state <= CAR_TRAVEL;	// keep direction
						end else if (behind) begin
							dir_up <= !dir_up;
							state  <= CAR_TRAVEL;
						end else begin
							state <= CAR_PARKED;
						end
					end
				end
				default: begin
					state <= CAR_PARKED;
				end
			endcase
		end
	end

	always_comb begin
		if (state == CAR_TRAVEL)
			engine = dir_up ? MOTOR_UP : MOTOR_DOWN;
		else
			engine = MOTOR_IDLE;
	end

	// open_btn is only honoured with nothing waiting
	assign parked = (state == CAR_PARKED) && !(|all_calls);

	// every call at the stop floor is dropped while the door is in use
	always_comb begin
		cancel.cab       = door_busy ? floor_bit : '0;
		cancel.hall_up   = door_busy ? floor_bit : '0;
		cancel.hall_down = door_busy ? floor_bit : '0;
	end

endmodule

`default_nettype wire

// File: logic/door_sequencer.sv
// door sequencer: open, dwell and close steps with dwell timer and door buttons
`timescale 1ns/1ps
`default_nettype none

module door_sequencer (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   door_request,
	input  wire                   parked,
	input  wire                   open_btn,
	input  wire                   close_btn,
	output elevator_pkg::door_cmd_t door_cmd,
	output logic                  door_done
);
	import elevator_pkg::*;

	localparam dwell_count_t DWELL_LAST = dwell_count_t'(DOOR_DWELL_CYCLES - 1);

	door_state_t  state;
	dwell_count_t dwell_count;
	logic         start;

	// open_btn only starts a cycle for a car at rest
	assign start = door_request || (open_btn && parked);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state       <= DS_IDLE;
			dwell_count <= '0;
		end else begin
			case (state)
				DS_IDLE: begin
					if (start)
						state <= DS_OPEN;
				end
				DS_OPEN: begin
					state       <= DS_DWELL;
					dwell_count <= '0;	// dwell restarts on every open
				end
				DS_DWELL: begin
					if (close_btn || dwell_count == DWELL_LAST)
						state <= DS_CLOSE;	// close cuts the dwell short
					else
						dwell_count <= dwell_count + 1'b1;
				end
				DS_CLOSE: begin
					if (open_btn)
						state <= DS_OPEN;	// reopen from closing
					else
						state <= DS_IDLE;
				end
				default: begin
					state <= DS_IDLE;
				end
			endcase
		end
	end

	always_comb begin
		case (state)
			DS_OPEN, DS_DWELL: door_cmd = DOOR_OPEN;
			DS_CLOSE:          door_cmd = DOOR_CLOSE;
			default:           door_cmd = DOOR_IDLE;
		endcase
	end

	// close step completes unless the door is reopened
	assign door_done = (state == DS_CLOSE) && !open_btn;

endmodule

`default_nettype wire

// File: logic/elevator_pkg.sv
// elevator package: floor and call types, motor and door commands, state enums, timing constants
`default_nettype none

package elevator_pkg;

	localparam int FLOOR_COUNT       = 8;
	localparam int DOOR_DWELL_CYCLES = 5;	// dwell cycles after the open cycle
	localparam int HALF_FLOOR_STEPS  = 2;	// travel cycles per floor

	typedef logic [$clog2(FLOOR_COUNT)-1:0]      floor_t;
	typedef logic [FLOOR_COUNT-1:0]              floor_mask_t;	// one bit per floor
	typedef logic [2:0]                          dwell_count_t;
	typedef logic [$clog2(HALF_FLOOR_STEPS)-1:0] step_count_t;	// half-floor position

	// all three call groups, used for pins, pending calls and cancels
	typedef struct packed {
		floor_mask_t cab;
		floor_mask_t hall_up;
		floor_mask_t hall_down;
	} call_set_t;

	typedef enum logic [1:0] {
		MOTOR_IDLE = 2'd0,
		MOTOR_DOWN = 2'd1,
		MOTOR_UP   = 2'd2
	} motor_cmd_t;

	typedef enum logic [1:0] {
		DOOR_IDLE  = 2'd0,
		DOOR_OPEN  = 2'd1,
		DOOR_CLOSE = 2'd2
	} door_cmd_t;

	typedef enum logic [1:0] {
		DS_IDLE,
		DS_OPEN,	// single open cycle
		DS_DWELL,
		DS_CLOSE
	} door_state_t;

	typedef enum logic [1:0] {
		CAR_PARKED,
		CAR_TRAVEL,
		CAR_ARRIVE,	// engine off, door request follows
		CAR_SERVE	// waiting for the door cycle
	} car_state_t;

endpackage

`default_nettype wire

// File: logic/elevator_top.sv
// elevator top level: call register, door sequencer and car controller
`timescale 1ns/1ps
`default_nettype none

module elevator_top (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      open_btn,
	input  wire                      close_btn,
	input  wire elevator_pkg::call_set_t buttons,
	output elevator_pkg::motor_cmd_t     engine,
	output elevator_pkg::door_cmd_t      door,
	output elevator_pkg::floor_t         level_display
);
	import elevator_pkg::*;

	call_set_t pending;
	call_set_t cancel;
	logic      door_request;
	logic      parked;
	logic      door_done;

	call_register u_call_register (
		.clk     (clk),
		.reset   (reset),
		.buttons (buttons),
		.cancel  (cancel),
		.pending (pending)
	);

	door_sequencer u_door_sequencer (
		.clk          (clk),
		.reset        (reset),
		.door_request (door_request),
		.parked       (parked),
		.open_btn     (open_btn),
		.close_btn    (close_btn),
		.door_cmd     (door),
		.door_done    (door_done)
	);

	car_controller u_car_controller (
		.clk           (clk),
		.reset         (reset),
		.pending       (pending),
		.door_done     (door_done),
		.engine        (engine),
		.level_display (level_display),
		.door_request  (door_request),
		.parked        (parked),
		.cancel        (cancel)
	);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the elevator testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module elevator_tb \
	-f flist.f -o elevator_sim \
	&& ./obj_dir/elevator_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
! grep -q "Finished with errors" sim.log \
	&& grep -q "Finished with no errors" sim.log \
	|| { echo "simulation reported failure"; exit 1; }

// File: verif/elevator_cases.txt
# columns: name start_floor press_count (group floor cycle)... stop_count stop_floors...
# groups: c cab, u hall up, d hall down, k close in dwell, o close then reopen, h press at open door
idle_after_reset 0 0 0
single_cab 0 1 c 5 0 1 5
return_home 5 1 c 0 0 1 0
cab_order 0 3 c 2 0 c 6 0 c 4 0 3 2 4 6
down_to_zero 6 1 c 0 0 1 0
hall_passing 0 2 d 3 0 c 6 0 2 6 3
up_to_seven 3 1 c 7 0 1 7
hall_down_alone 7 1 d 3 0 1 3
door_close_early 3 2 c 6 0 k 0 0 1 6
door_reopen 6 2 c 2 0 o 0 0 1 2
press_at_open_door 2 2 c 4 0 h 0 0 1 4
press_while_parked 4 1 c 4 0 1 4
hall_up_here 4 1 u 4 0 1 4
late_call 4 2 c 7 0 c 6 3 2 6 7

// File: verif/elevator_checker.sv
// elevator checker: concurrent assertions on the top-level outputs
`timescale 1ns/1ps
`default_nettype none

module elevator_checker (
	input wire                           clk,
	input wire                           reset,
	input wire                           open_btn,
	input wire elevator_pkg::motor_cmd_t engine,
	input wire elevator_pkg::door_cmd_t  door,
	input wire elevator_pkg::floor_t     level_display
);
	import elevator_pkg::*;

	// outputs at rest while reset is held
	reset_values: assert property (@(posedge clk)
		!reset |-> (engine == MOTOR_IDLE && door == DOOR_IDLE && level_display == '0))
		else $error("outputs not at rest during reset");

	// car never moves with the door out of idle
	no_move_with_door: assert property (@(posedge clk) disable iff (!reset)
		(door != DOOR_IDLE) |-> (engine == MOTOR_IDLE))
		else $error("engine active while the door is in use");

	// open during the close step brings the door back
	reopen_from_close: assert property (@(posedge clk) disable iff (!reset)
		(door == DOOR_CLOSE && open_btn) |=> (door == DOOR_OPEN))
		else $error("door did not reopen from the close step");

	// floor only changes after two travel cycles in one direction
	floor_needs_travel: assert property (@(posedge clk) disable iff (!reset)
		$changed(level_display) |->
			($past(engine) != MOTOR_IDLE && $past(engine, 2) == $past(engine)))
		else $error("level display changed without a full floor of travel");

endmodule

`default_nettype wire

// File: verif/elevator_tb.sv
// elevator testbench: clock, reset, cases from file, stop monitor, checks, watchdog, report
`timescale 1ns/1ps
`default_nettype none

module elevator_tb;
	import elevator_pkg::*;

	localparam int MAX_TESTS       = 24;
	localparam int MAX_PRESS       = 8;
	localparam int MAX_STOPS       = 16;
	localparam int QUIET_CYCLES    = 20;	// parked with door idle this long ends a test
	localparam int CYCLES_PER_TEST = 400;

	logic       clk;
	logic       reset;
	logic       open_btn;
	logic       close_btn;
	call_set_t  buttons;
	motor_cmd_t engine;
	door_cmd_t  door;
	floor_t     level_display;

	string t_name [MAX_TESTS];
	int    t_start [MAX_TESTS];
	int    t_npress [MAX_TESTS];
	string p_group [MAX_TESTS][MAX_PRESS];
	int    p_floor [MAX_TESTS][MAX_PRESS];
	int    p_cycle [MAX_TESTS][MAX_PRESS];
	int    t_nstops [MAX_TESTS];
	int    t_stops [MAX_TESTS][MAX_STOPS];
	int    stops [$];
	int    n_tests;
	int    errors;
	int    failed_tests;
	int    seed;
	bit    loaded;
	bit    cur_dir;	// last travel direction, 1 up

	elevator_top DUT (
		.clk           (clk),
		.reset         (reset),
		.open_btn      (open_btn),
		.close_btn     (close_btn),
		.buttons       (buttons),
		.engine        (engine),
		.door          (door),
		.level_display (level_display)
	);

	bind elevator_top elevator_checker checker_inst (
		.clk           (clk),
		.reset         (reset),
		.open_btn      (open_btn),
		.engine        (engine),
		.door          (door),
		.level_display (level_display)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input int got, input int expected);
		if (got !== expected) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected);
			errors++;
		end
	endtask

	function automatic bit calls_beyond(input int mask, input int f, input bit up);
		bit hit;
		hit = 1'b0;
		for (int i = 0; i < FLOOR_COUNT; i++) begin
			if (mask[i] && (up ? (i > f) : (i < f)))
				hit = 1'b1;
		end
		return hit;
	endfunction

	// direction rule on arrival at floor f
	function automatic bit stops_here(input int cab, input int up, input int dn, input int f,
			input bit dir);
		bit same_dir;
		bit other_dir;
		same_dir  = dir ? up[f] : dn[f];
		other_dir = dir ? dn[f] : up[f];
		return cab[f] || same_dir || (other_dir && !calls_beyond(cab | up | dn, f, dir));
	endfunction

	task automatic load_cases();
		int    fd;
		int    code;
		string tok;
		string rest;
		fd = $fopen("verif/elevator_cases.txt", "r");
		n_tests = 0;
		if (fd == 0) begin
			$display("Could not open the cases file");
			errors++;
		end else begin
			while (!$feof(fd) && n_tests < MAX_TESTS - 1) begin
				code = $fscanf(fd, "%s", tok);
				if (code != 1)
					break;
				if (tok.substr(0, 0) == "#") begin
					code = $fgets(rest, fd);	// skip comment line
				end else begin
					t_name[n_tests] = tok;
					code = $fscanf(fd, "%d %d", t_start[n_tests], t_npress[n_tests]);
					for (int p = 0; p < t_npress[n_tests]; p++)
						code = $fscanf(fd, "%s %d %d", p_group[n_tests][p],
							p_floor[n_tests][p], p_cycle[n_tests][p]);
					code = $fscanf(fd, "%d", t_nstops[n_tests]);
					for (int s = 0; s < t_nstops[n_tests]; s++)
						code = $fscanf(fd, "%d", t_stops[n_tests][s]);
					n_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	// expected stops for calls all pressed in one cycle, car at rest
	task automatic expect_stops(input int idx);
		int cab;
		int up;
		int dn;
		int f;
		int guard;
		bit dir;
		cab = 0;
		up  = 0;
		dn  = 0;
		for (int p = 0; p < t_npress[idx]; p++) begin
			if (p_group[idx][p] == "c")
				cab = cab | (1 << p_floor[idx][p]);
			else if (p_group[idx][p] == "u")
				up = up | (1 << p_floor[idx][p]);
			else
				dn = dn | (1 << p_floor[idx][p]);
		end
		f = t_start[idx];
		dir = cur_dir;
		guard = 0;
		t_nstops[idx] = 0;
		while ((cab | up | dn) != 0 && guard < 64) begin
			guard++;
			if (((cab | up | dn) >> f) & 1) begin
				t_stops[idx][t_nstops[idx]] = f;
				t_nstops[idx]++;
				cab = cab & ~(1 << f);
				up  = up & ~(1 << f);
				dn  = dn & ~(1 << f);
			end
			if (!calls_beyond(cab | up | dn, f, dir)) begin
				if (calls_beyond(cab | up | dn, f, !dir))
					dir = !dir;
				else
					break;
			end
			f = dir ? f + 1 : f - 1;
			while (!stops_here(cab, up, dn, f, dir) && calls_beyond(cab | up | dn, f, dir))
				f = dir ? f + 1 : f - 1;
			if (stops_here(cab, up, dn, f, dir)) begin
				t_stops[idx][t_nstops[idx]] = f;
				t_nstops[idx]++;
				cab = cab & ~(1 << f);
				up  = up & ~(1 << f);
				dn  = dn & ~(1 << f);
			end
		end
	endtask

	task automatic run_test(input int idx);
		int        cyc;
		int        quiet;
		int        last_press;
		int        door_phase;
		int        here_phase;
		int        open_len;
		int        errors_before;
		bit        arm_close;
		bit        arm_open;
		bit        arm_here;
		call_set_t next;
		door_cmd_t prev_door;
		floor_t    prev_level;
		errors_before = errors;
		stops.delete();
		last_press = 0;
		arm_close  = 1'b0;
		arm_open   = 1'b0;
		arm_here   = 1'b0;
		for (int p = 0; p < t_npress[idx]; p++) begin
			if (p_cycle[idx][p] > last_press)
				last_press = p_cycle[idx][p];
			if (p_group[idx][p] == "k" || p_group[idx][p] == "o")
				arm_close = 1'b1;
			if (p_group[idx][p] == "o")
				arm_open = 1'b1;
			if (p_group[idx][p] == "h")
				arm_here = 1'b1;
		end
		check_value("level_display", int'(level_display), t_start[idx]);
		prev_door  = door;
		prev_level = level_display;
		cyc        = 0;
		quiet      = 0;
		door_phase = 0;
		here_phase = 0;
		open_len   = 0;
		while (quiet < QUIET_CYCLES) begin
			@(posedge clk);
			next = '0;
			for (int p = 0; p < t_npress[idx]; p++) begin
				if (p_cycle[idx][p] == cyc) begin
					if (p_group[idx][p] == "c")
						next.cab[p_floor[idx][p]] = 1'b1;
					else if (p_group[idx][p] == "u")
						next.hall_up[p_floor[idx][p]] = 1'b1;
					else if (p_group[idx][p] == "d")
						next.hall_down[p_floor[idx][p]] = 1'b1;
				end
			end
			if (here_phase == 1)
				next.cab[prev_level] = 1'b1;	// press at the open door
			buttons   <= next;
			close_btn <= (door_phase == 2);	// lands in the dwell
			open_btn  <= (door_phase == 3) && arm_open;	// lands in the close step
			@(negedge clk);
			if (door == DOOR_OPEN && prev_door == DOOR_IDLE)
				stops.push_back(int'(level_display));
			// one open cycle and the full dwell, or open plus two dwell cycles after close
			if (door == DOOR_OPEN) begin
				open_len++;
			end else begin
				if (door == DOOR_CLOSE && prev_door == DOOR_OPEN)
					check_value("door open cycles", open_len,
						(door_phase == 3) ? 3 : 1 + DOOR_DWELL_CYCLES);
				open_len = 0;
			end
			if (level_display != prev_level)
				check_value("level_display step",
					(int'(level_display) > int'(prev_level)) ?
					int'(level_display) - int'(prev_level) :
					int'(prev_level) - int'(level_display), 1);
			if (door_phase == 0 && arm_close && door == DOOR_OPEN)
				door_phase = 1;
			else if (door_phase > 0 && door_phase < 4)
				door_phase++;
			if (here_phase == 0 && arm_here && door == DOOR_OPEN)
				here_phase = 1;
			else if (here_phase == 1)
				here_phase = 2;
			prev_door  = door;
			prev_level = level_display;
			if (engine == MOTOR_IDLE && door == DOOR_IDLE && cyc >= last_press)
				quiet++;
			else
				quiet = 0;
			cyc++;
		end
		check_value("stop count", stops.size(), t_nstops[idx]);
		for (int s = 0; s < stops.size() && s < t_nstops[idx]; s++)
			check_value($sformatf("stop %0d floor", s), stops[s], t_stops[idx][s]);
		if (errors == errors_before) begin
			$display("test %s: passed with %0d stops", t_name[idx], stops.size());
		end else begin
			$display("test %s: failed", t_name[idx]);
			failed_tests++;
		end
	endtask

	initial begin
		int r;
		int pos;
		seed         = 32'h055a_855c;
		reset        = 1'b1;
		open_btn     = 1'b0;
		close_btn    = 1'b0;
		buttons      = '0;
		errors       = 0;
		failed_tests = 0;
		cur_dir      = 1'b1;	// direction after reset
		loaded       = 1'b0;
		load_cases();
		loaded = 1'b1;
		#1 reset = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		check_value("engine", int'(engine), int'(MOTOR_IDLE));
		check_value("door", int'(door), int'(DOOR_IDLE));
		check_value("level_display", int'(level_display), 0);
		for (int i = 0; i < n_tests; i++)
			run_test(i);
		// car rests at the last expected stop, facing the way it last travelled
		pos = 0;
		for (int i = 0; i < n_tests; i++) begin
			for (int s = 0; s < t_nstops[i]; s++) begin
				if (t_stops[i][s] > pos)
					cur_dir = 1'b1;
				else if (t_stops[i][s] < pos)
					cur_dir = 1'b0;
				pos = t_stops[i][s];
			end
		end
		// random calls, all in one cycle, expected from the direction rule
		t_name[n_tests]   = "random_calls";
		t_start[n_tests]  = pos;
		t_npress[n_tests] = 4;
		for (int p = 0; p < 4; p++) begin
			r = $random(seed);
			p_floor[n_tests][p] = r & 7;
			p_cycle[n_tests][p] = 0;
			case (((r >> 3) & 3) % 3)
				0:       p_group[n_tests][p] = "c";
				1:       p_group[n_tests][p] = "u";
				default: p_group[n_tests][p] = "d";
			endcase
		end
		expect_stops(n_tests);
		run_test(n_tests);
		$display("%0d tests run, %0d failed, %0d errors", n_tests + 1, failed_tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		wait (loaded);
		repeat ((n_tests + 2) * CYCLES_PER_TEST) @(posedge clk);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
